// ==== sources.f ====
+incdir+.
vgaPkg.sv
vgaTiming.sv
itemPicker.sv
gridPainter.sv
pixelOutput.sv
vgaTop.sv
tbVga.sv

// ==== Makefile ====
# Verilator build and run for the VGA pattern generator

VERILATOR ?= verilator
TOP ?= tbVga
LINT_TOP ?= vgaTop
FILELIST ?= sources.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== tbVgaModel.svh ====
// reference model of the timing counters, item picker and output pipeline, with prediction tasks

// mirrored line and frame counters after the latest edge
int modelH;
int modelV;
// counters seen after the last three edges, newest first
logic histValid [3];
int histH [3];
int histV [3];
// switch levels sampled at the last two edges
logic gridHist [2];
logic itemHist [2];
// item counters and the frame latch
int xCount;
int yCount;
int redCount;
int greenCount;
int blueCount;
int latchX;
int latchY;
int latchR;
int latchG;
int latchB;
// predicted outputs
logic [7:0] expR;
logic [7:0] expG;
logic [7:0] expB;
logic expHs;
logic expVs;
// coverage tallies
int gridPixels;
int itemPixels;
int latchMoves;

// colour step, back to 1 and not 0 past full scale
function automatic int addColor(input int value, input int step);
	if (value + step > 255)
		return 1;
	return value + step;
endfunction

// outputs as they leave reset
task automatic blankOutputs();
	expR = 8'h00;
	expG = 8'h00;
	expB = 8'h00;
	expHs = 1'b1;
	expVs = 1'b1;
endtask

task automatic resetModel();
	modelH = 0;
	modelV = 0;
	for (int i = 0; i < 3; i++)
	begin
		histValid[i] = 1'b0;
		histH[i] = 0;
		histV[i] = 0;
	end
	for (int i = 0; i < 2; i++)
	begin
		gridHist[i] = 1'b0;
		itemHist[i] = 1'b0;
	end
	xCount = itemXMin;
	yCount = itemYMin;
	redCount = 1;
	greenCount = 1;
	blueCount = 1;
	latchX = itemXMin;
	latchY = itemYMin;
	latchR = 1;
	latchG = 1;
	latchB = 1;
	blankOutputs();
endtask

// pixel at counters h and v, with the switches that stage 2 saw
task automatic predictPixel(input int h, input int v, input logic gridOn, input logic itemOn);
	int x;
	int y;
	logic inWindow;
	logic onItem;
	logic onGrid;
	x = h - (hSyncLen + hBack);
	y = v - (vSyncLen + vBack);
	expHs = (h >= hSyncLen);
	expVs = (v >= vSyncLen);
	// half-open visible window
	inWindow = (x >= 0) && (x < hVisible) && (y >= 0) && (y < vVisible);
	onItem = (x >= latchX) && (x < latchX + itemSize) &&
		(y >= latchY) && (y < latchY + itemSize);
	// cell lines plus the right and bottom border
	onGrid = ((x % gridPitch) < lineWidth) || ((y % gridPitch) < lineWidth) ||
		(x >= hVisible - lineWidth) || (y >= vVisible - lineWidth);
	expR = 8'h00;
	expG = 8'h00;
	expB = 8'h00;
	if (inWindow && itemOn && onItem)
	begin
		expR = 8'(latchR);
		expG = 8'(latchG);
		expB = 8'(latchB);
		itemPixels++;
	end
	else if (inWindow && gridOn && onGrid)
	begin
		expR = 8'hFF;
		expG = 8'hFF;
		expB = 8'hFF;
		gridPixels++;
	end
endtask

// one rising edge, with the inputs the DUT sampled on it
task automatic stepModel(input logic rstIn, input logic gridIn, input logic itemIn);
	logic frameFlag;
	if (rstIn)
		resetModel();
	else
	begin
		// frame start follows the counters at the origin by one edge
		frameFlag = histValid[0] && (histH[0] == 0) && (histV[0] == 0);
		if (frameFlag)
		begin
			if ((latchX != xCount) || (latchY != yCount))
				latchMoves++;
			latchX = xCount;
			latchY = yCount;
			latchR = redCount;
			latchG = greenCount;
			latchB = blueCount;
		end
		xCount = (xCount >= itemXMax) ? itemXMin : xCount + 1;
		yCount = (yCount >= itemYMax) ? itemYMin : yCount + 1;
		redCount = addColor(redCount, 1);
		greenCount = addColor(greenCount, 2);
		blueCount = addColor(blueCount, 4);
		for (int i = 2; i > 0; i--)
		begin
			histValid[i] = histValid[i - 1];
			histH[i] = histH[i - 1];
			histV[i] = histV[i - 1];
		end
		histValid[0] = 1'b1;
		histH[0] = modelH;
		histV[0] = modelV;
		if (modelH == hTotal - 1)
		begin
			modelH = 0;
			modelV = (modelV == vTotal - 1) ? 0 : modelV + 1;
		end
		else
			modelH++;
		gridHist[1] = gridHist[0];
		gridHist[0] = gridIn;
		itemHist[1] = itemHist[0];
		itemHist[0] = itemIn;
		// outputs show the counters of three edges back
		// the latch only moves in vertical blanking, so its current value serves
		if (histValid[2])
			predictPixel(histH[2], histV[2], gridHist[1], itemHist[1]);
		else
			blankOutputs();
	end
endtask

// ==== tbVga.sv ====
// testbench for the VGA pattern generator with clock, reset, random switches, model checks and timeout
`timescale 1ns/1ps

module tbVga;

	// ===================================================================
	// small screen of 1200 cycles per frame
	// ===================================================================
	localparam int hTotal = 40;
	localparam int hVisible = 24;
	localparam int hSyncLen = 4;
	localparam int hBack = 6;
	localparam int vTotal = 30;
	localparam int vVisible = 20;
	localparam int vSyncLen = 2;
	localparam int vBack = 4;
	localparam int gridPitch = 8;
	localparam int lineWidth = 2;
	localparam int itemSize = 3;
	localparam int itemXMin = 2;
	localparam int itemXMax = 18;
	localparam int itemYMin = 2;
	localparam int itemYMax = 14;

	localparam int frameCycles = hTotal * vTotal;
	localparam int runFrames = 8;
	localparam int resetCycles = 3;
	localparam int runCycles = resetCycles + runFrames * frameCycles;
	// eight frames plus margin
	localparam int cycleLimit = runFrames * frameCycles + 2400;
	localparam int seed = 22934;

	logic VGA_clk;
	logic reset;
	logic showGrid;
	logic showItem;
	logic [7:0] VGA_R;
	logic [7:0] VGA_G;
	logic [7:0] VGA_B;
	logic VGA_HS;
	logic VGA_VS;

	int syncErrors;
	int rgbErrors;
	int otherErrors;
	int checkCount;
	int cycleCount;

	`include "tbVgaModel.svh"

	vgaTop #(
		.hTotal(hTotal), .hVisible(hVisible), .hSync(hSyncLen), .hBack(hBack),
		.vTotal(vTotal), .vVisible(vVisible), .vSync(vSyncLen), .vBack(vBack),
		.gridPitch(gridPitch), .lineWidth(lineWidth), .itemSize(itemSize),
		.itemXMin(itemXMin), .itemXMax(itemXMax), .itemYMin(itemYMin), .itemYMax(itemYMax)
	) u_dut (
		.VGA_clk(VGA_clk), .reset(reset), .showGrid(showGrid), .showItem(showItem),
		.VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B), .VGA_HS(VGA_HS), .VGA_VS(VGA_VS)
	);

	// 40 ns pixel clock
	initial
	begin
		VGA_clk = 1'b0;
		forever
			#20 VGA_clk = ~VGA_clk;
	end

	// watchdog on the cycle count
	initial
	begin
		cycleCount = 0;
		while (cycleCount <= cycleLimit)
		begin
			@(posedge VGA_clk);
			cycleCount++;
		end
		$display("run did not end within %0d cycles", cycleLimit);
		$display("Finished with errors");
		$finish;
	end

	// all five outputs against the model
	task automatic compareOutputs(input int cycle);
		checkCount++;
		if (VGA_HS !== expHs)
		begin
			syncErrors++;
			$display("mismatch VGA_HS cycle %0d expected %h actual %h", cycle, expHs, VGA_HS);
		end
		if (VGA_VS !== expVs)
		begin
			syncErrors++;
			$display("mismatch VGA_VS cycle %0d expected %h actual %h", cycle, expVs, VGA_VS);
		end
		if (VGA_R !== expR)
		begin
			rgbErrors++;
			$display("mismatch VGA_R cycle %0d expected %h actual %h", cycle, expR, VGA_R);
		end
		if (VGA_G !== expG)
		begin
			rgbErrors++;
			$display("mismatch VGA_G cycle %0d expected %h actual %h", cycle, expG, VGA_G);
		end
		if (VGA_B !== expB)
		begin
			rgbErrors++;
			$display("mismatch VGA_B cycle %0d expected %h actual %h", cycle, expB, VGA_B);
		end
	endtask

	// ===================================================================
	// stimulus and checking
	// ===================================================================
	initial
	begin : mainRun
		int resetAt;
		int resetLen;
		int nextToggle;
		int pick;
		void'($urandom(seed));
		reset = 1'b1;
		showGrid = 1'b1;
		showItem = 1'b0;
		syncErrors = 0;
		rgbErrors = 0;
		otherErrors = 0;
		checkCount = 0;
		gridPixels = 0;
		itemPixels = 0;
		latchMoves = 0;
		resetModel();
		// one mid-run reset somewhere in frames 3 to 5
		resetAt = int'($urandom_range(3 * frameCycles, 5 * frameCycles));
		resetLen = int'($urandom_range(1, 3));
		nextToggle = int'($urandom_range(100, 600));
		for (int cyc = 0; cyc < runCycles; cyc++)
		begin
			@(posedge VGA_clk);
			// outputs settle right after the edge
			#1;
			stepModel(reset, showGrid, showItem);
			compareOutputs(cyc);
			// drive 2 ns after the edge
			#1;
			reset = (cyc < resetCycles - 1) ||
				((cyc >= resetAt) && (cyc < resetAt + resetLen));
			if (cyc == nextToggle)
			begin
				pick = int'($urandom_range(0, 2));
				if (pick != 1)
					showGrid = !showGrid;
				if (pick != 0)
					showItem = !showItem;
				nextToggle = cyc + int'($urandom_range(30, 700));
			end
		end
		// the run must have shown both overlays and a moving marker
		if (gridPixels == 0)
		begin
			otherErrors++;
			$display("no grid pixel was expected during the run");
		end
		if (itemPixels == 0)
		begin
			otherErrors++;
			$display("no item pixel was expected during the run");
		end
		if (latchMoves < 2)
		begin
			otherErrors++;
			$display("item marker did not move between frames");
		end
		$display("checks %0d, sync errors %0d, rgb errors %0d, other errors %0d",
			checkCount, syncErrors, rgbErrors, otherErrors);
		if (syncErrors + rgbErrors + otherErrors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== vgaTop.sv ====
// top level of the VGA test-pattern generator wiring timing, picker, painter and output stages
`timescale 1ns/1ps

module vgaTop
#(
	parameter int hTotal = vgaPkg::defaultHTotal,
	parameter int hVisible = vgaPkg::defaultHVisible,
	parameter int hSync = vgaPkg::defaultHSync,
	parameter int hBack = vgaPkg::defaultHBack,
	parameter int vTotal = vgaPkg::defaultVTotal,
	parameter int vVisible = vgaPkg::defaultVVisible,
	parameter int vSync = vgaPkg::defaultVSync,
	parameter int vBack = vgaPkg::defaultVBack,
	parameter int gridPitch = vgaPkg::defaultGridPitch,
	parameter int lineWidth = vgaPkg::defaultLineWidth,
	parameter int itemSize = vgaPkg::defaultItemSize,
	parameter int itemXMin = 260,
	parameter int itemXMax = 1020,
	parameter int itemYMin = 225,
	parameter int itemYMax = 795
)
(
	input logic VGA_clk,
	input logic reset,
	input logic showGrid,
	input logic showItem,
	output vgaPkg::colorT VGA_R,
	output vgaPkg::colorT VGA_G,
	output vgaPkg::colorT VGA_B,
	output logic VGA_HS,
	output logic VGA_VS
);

	// ===================================================================
	// stage 1, timing
	// ===================================================================
	vgaPkg::coordT xPos;
	vgaPkg::coordT yPos;
	logic stage1Active;
	logic stage1HSync;
	logic stage1VSync;
	logic frameStart;

	// item marker, held between frame starts
	vgaPkg::coordT itemX;
	vgaPkg::coordT itemY;
	vgaPkg::colorT itemRed;
	vgaPkg::colorT itemGreen;
	vgaPkg::colorT itemBlue;

	// stage 2, classified pixel
	vgaPkg::pixelClassT pixelClass;
	logic stage2Active;
	logic stage2HSync;
	logic stage2VSync;

	vgaTiming #(
		.hTotal(hTotal), .hVisible(hVisible), .hSyncLen(hSync), .hBack(hBack),
		.vTotal(vTotal), .vVisible(vVisible), .vSyncLen(vSync), .vBack(vBack)
	) uTiming (
		.VGA_clk(VGA_clk), .reset(reset), .xPos(xPos), .yPos(yPos),
		.active(stage1Active), .hSync(stage1HSync), .vSync(stage1VSync),
		.frameStart(frameStart)
	);

	// marker position and colour
	itemPicker #(
		.itemXMin(itemXMin), .itemXMax(itemXMax), .itemYMin(itemYMin), .itemYMax(itemYMax)
	) uPicker (
		.VGA_clk(VGA_clk), .reset(reset), .frameStart(frameStart),
		.itemX(itemX), .itemY(itemY),
		.itemRed(itemRed), .itemGreen(itemGreen), .itemBlue(itemBlue)
	);

	// ===================================================================
	// stage 2 and 3
	// ===================================================================
	gridPainter #(
		.gridPitch(gridPitch), .lineWidth(lineWidth), .itemSize(itemSize),
		.hVisible(hVisible), .vVisible(vVisible)
	) uPainter (
		.VGA_clk(VGA_clk), .reset(reset), .xPos(xPos), .yPos(yPos),
		.active(stage1Active), .hSync(stage1HSync), .vSync(stage1VSync),
		.itemX(itemX), .itemY(itemY), .showGrid(showGrid), .showItem(showItem),
		.pixelClass(pixelClass), .activeOut(stage2Active),
		.hSyncOut(stage2HSync), .vSyncOut(stage2VSync)
	);

	pixelOutput uOutput (
		.VGA_clk(VGA_clk), .reset(reset), .pixelClass(pixelClass),
		.active(stage2Active), .hSync(stage2HSync), .vSync(stage2VSync),
		.itemRed(itemRed), .itemGreen(itemGreen), .itemBlue(itemBlue),
		.VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B), .VGA_HS(VGA_HS), .VGA_VS(VGA_VS)
	);

endmodule

// ==== pixelOutput.sv ====
// output stage that maps pixel class to RGB, blanks outside the window and registers sync
`timescale 1ns/1ps

module pixelOutput
(
	input logic VGA_clk,
	input logic reset,
	input vgaPkg::pixelClassT pixelClass,
	input logic active,
	input logic hSync,
	input logic vSync,
	input vgaPkg::colorT itemRed,
	input vgaPkg::colorT itemGreen,
	input vgaPkg::colorT itemBlue,
	output vgaPkg::colorT VGA_R,
	output vgaPkg::colorT VGA_G,
	output vgaPkg::colorT VGA_B,
	output logic VGA_HS,
	output logic VGA_VS
);

	vgaPkg::colorT redNext;
	vgaPkg::colorT greenNext;
	vgaPkg::colorT blueNext;

	// class to colour, black unless in the visible window
	always_comb
	begin
		redNext = '0;
		greenNext = '0;
		blueNext = '0;
		if (active)
		begin
			case (pixelClass)
				vgaPkg::classGrid:
				begin
					// white grid lines
					redNext = 8'hFF;
					greenNext = 8'hFF;
					blueNext = 8'hFF;
				end
				vgaPkg::classItem:
				begin
					// latched colour, constant over the frame
					redNext = itemRed;
					greenNext = itemGreen;
					blueNext = itemBlue;
				end
				default:
				begin
					redNext = '0;
					greenNext = '0;
					blueNext = '0;
				end
			endcase
		end
	end

	// stage 3 registers
	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			VGA_R <= '0;
			VGA_G <= '0;
			VGA_B <= '0;
			VGA_HS <= 1'b1;
			VGA_VS <= 1'b1;
		end
		else
		begin
			VGA_R <= redNext;
			VGA_G <= greenNext;
			VGA_B <= blueNext;
			VGA_HS <= hSync;
			VGA_VS <= vSync;
		end
	end

	// nothing lit on the cycle after a blanked pixel
	assert property (@(posedge VGA_clk) disable iff (reset)
		!active |=> ((VGA_R == '0) && (VGA_G == '0) && (VGA_B == '0)));

endmodule

// ==== gridPainter.sv ====
// grid and item painter that classifies each pixel with cell phase counters
`timescale 1ns/1ps

module gridPainter
#(
	parameter int gridPitch = vgaPkg::defaultGridPitch,
	parameter int lineWidth = vgaPkg::defaultLineWidth,
	parameter int itemSize = vgaPkg::defaultItemSize,
	parameter int hVisible = vgaPkg::defaultHVisible,
	parameter int vVisible = vgaPkg::defaultVVisible
)
(
	input logic VGA_clk,
	input logic reset,
	input vgaPkg::coordT xPos,
	input vgaPkg::coordT yPos,
	input logic active,
	input logic hSync,
	input logic vSync,
	input vgaPkg::coordT itemX,
	input vgaPkg::coordT itemY,
	input logic showGrid,
	input logic showItem,
	output vgaPkg::pixelClassT pixelClass,
	output logic activeOut,
	output logic hSyncOut,
	output logic vSyncOut
);

	localparam vgaPkg::coordT pitchLast = vgaPkg::coordT'(gridPitch - 1);
	localparam vgaPkg::coordT lineW = vgaPkg::coordT'(lineWidth);
	localparam vgaPkg::coordT side = vgaPkg::coordT'(itemSize);
	localparam vgaPkg::coordT xLast = vgaPkg::coordT'(hVisible - 1);
	localparam vgaPkg::coordT yEnd = vgaPkg::coordT'(vVisible);
	// border lines along the right and bottom edges
	localparam vgaPkg::coordT rightEdge = vgaPkg::coordT'(hVisible - lineWidth);
	localparam vgaPkg::coordT bottomEdge = vgaPkg::coordT'(vVisible - lineWidth);

	vgaPkg::coordT colPhase;
	vgaPkg::coordT rowPhase;
	logic onGrid;
	logic onItem;
	vgaPkg::pixelClassT classNext;

	// ===================================================================
	// cell phase counters
	// ===================================================================

	// column phase of the pixel now at the input
	// held at 0 in blanking so the first visible pixel starts a cell
	always_ff @(posedge VGA_clk)
	begin
		if (reset || !active)
			colPhase <= '0;
		else if (colPhase == pitchLast)
			colPhase <= '0;
		else
			colPhase <= colPhase + 1'b1;
	end

	// row phase, steps after the last visible pixel of each line
	// out-of-window rows read as yPos >= vVisible, wrapped ones included
	always_ff @(posedge VGA_clk)
	begin
		if (reset || (yPos >= yEnd))
			rowPhase <= '0;
		else if (active && (xPos == xLast))
		begin
			if (rowPhase == pitchLast)
				rowPhase <= '0;
			else
				rowPhase <= rowPhase + 1'b1;
		end
	end

	// ===================================================================
	// classification
	// ===================================================================
	always_comb
	begin
		onGrid = (colPhase < lineW) || (rowPhase < lineW) ||
			(xPos >= rightEdge) || (yPos >= bottomEdge);
		// half-open square at the latched corner
		onItem = (xPos >= itemX) && (xPos < itemX + side) &&
			(yPos >= itemY) && (yPos < itemY + side);
		// item wins over grid
		if (!active)
			classNext = vgaPkg::classBackground;
		else if (showItem && onItem)
			classNext = vgaPkg::classItem;
		else if (showGrid && onGrid)
			classNext = vgaPkg::classGrid;
		else
			classNext = vgaPkg::classBackground;
	end

	// stage 2 registers, sync and window bits ride along
	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			pixelClass <= vgaPkg::classBackground;
			activeOut <= 1'b0;
			hSyncOut <= 1'b1;
			vSyncOut <= 1'b1;
		end
		else
		begin
			pixelClass <= classNext;
			activeOut <= active;
			hSyncOut <= hSync;
			vSyncOut <= vSync;
		end
	end

endmodule

// ==== itemPicker.sv ====
// item marker picker with wrapping position and colour counters latched at frame start
`timescale 1ns/1ps

module itemPicker
#(
	parameter int itemXMin = 260,
	parameter int itemXMax = 1020,
	parameter int itemYMin = 225,
	parameter int itemYMax = 795
)
(
	input logic VGA_clk,
	input logic reset,
	input logic frameStart,
	output vgaPkg::coordT itemX,
	output vgaPkg::coordT itemY,
	output vgaPkg::colorT itemRed,
	output vgaPkg::colorT itemGreen,
	output vgaPkg::colorT itemBlue
);

	localparam vgaPkg::coordT xMin = vgaPkg::coordT'(itemXMin);
	localparam vgaPkg::coordT xMax = vgaPkg::coordT'(itemXMax);
	localparam vgaPkg::coordT yMin = vgaPkg::coordT'(itemYMin);
	localparam vgaPkg::coordT yMax = vgaPkg::coordT'(itemYMax);

	vgaPkg::coordT xCount;
	vgaPkg::coordT yCount;
	vgaPkg::colorT redCount;
	vgaPkg::colorT greenCount;
	vgaPkg::colorT blueCount;

	// step by one, back to the low bound after the high bound
	function automatic vgaPkg::coordT nextPos(input vgaPkg::coordT value,
		input vgaPkg::coordT lo, input vgaPkg::coordT hi);
		if (value >= hi)
			return lo;
		return value + 1'b1;
	endfunction

	// add the step, back to 1 once the sum would pass 255
	function automatic vgaPkg::colorT nextColor(input vgaPkg::colorT value, input int step);
		logic [8:0] sum;
		sum = {1'b0, value} + 9'(step);
		if (sum > 9'd255)
			return 8'd1;
		return sum[7:0];
	endfunction

	// ===================================================================
	// free-running counters
	// ===================================================================
	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			xCount <= xMin;
			yCount <= yMin;
			redCount <= 8'd1;
			greenCount <= 8'd1;
			blueCount <= 8'd1;
		end
		else
		begin
			xCount <= nextPos(xCount, xMin, xMax);
			yCount <= nextPos(yCount, yMin, yMax);
			// three rates so the channels drift apart
			redCount <= nextColor(redCount, 1);
			greenCount <= nextColor(greenCount, 2);
			blueCount <= nextColor(blueCount, 4);
		end
	end

	// ===================================================================
	// per-frame latch
	// ===================================================================
	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			itemX <= xMin;
			itemY <= yMin;
			itemRed <= 8'd1;
			itemGreen <= 8'd1;
			itemBlue <= 8'd1;
		end
		else if (frameStart)
		begin
			// sample during blanking, held for the whole frame
			itemX <= xCount;
			itemY <= yCount;
			itemRed <= redCount;
			itemGreen <= greenCount;
			itemBlue <= blueCount;
		end
	end

	// marker column stays inside its range
	assert property (@(posedge VGA_clk) disable iff (reset)
		(itemX >= itemXMin) && (itemX <= itemXMax));

endmodule

// ==== vgaTiming.sv ====
// sync timing generator with line and frame counters, sync pulses, coordinates and frame start
`timescale 1ns/1ps

module vgaTiming
#(
	parameter int hTotal = vgaPkg::defaultHTotal,
	parameter int hVisible = vgaPkg::defaultHVisible,
	parameter int hSyncLen = vgaPkg::defaultHSync,
	parameter int hBack = vgaPkg::defaultHBack,
	parameter int vTotal = vgaPkg::defaultVTotal,
	parameter int vVisible = vgaPkg::defaultVVisible,
	parameter int vSyncLen = vgaPkg::defaultVSync,
	parameter int vBack = vgaPkg::defaultVBack
)
(
	input logic VGA_clk,
	input logic reset,
	output vgaPkg::coordT xPos,
	output vgaPkg::coordT yPos,
	output logic active,
	output logic hSync,
	output logic vSync,
	output logic frameStart
);

	// last count of a line and of a frame
	localparam vgaPkg::coordT hLast = vgaPkg::coordT'(hTotal - 1);
	localparam vgaPkg::coordT vLast = vgaPkg::coordT'(vTotal - 1);
	// visible window, half-open
	localparam vgaPkg::coordT hStart = vgaPkg::coordT'(hSyncLen + hBack);
	localparam vgaPkg::coordT hEnd = vgaPkg::coordT'(hSyncLen + hBack + hVisible);
	localparam vgaPkg::coordT vStart = vgaPkg::coordT'(vSyncLen + vBack);
	localparam vgaPkg::coordT vEnd = vgaPkg::coordT'(vSyncLen + vBack + vVisible);

	vgaPkg::coordT hCount;
	vgaPkg::coordT vCount;
	logic lineEnd;

	assign lineEnd = (hCount == hLast);

	// ===================================================================
	// line and frame counters
	// ===================================================================
	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else
		begin
			// pixel count, wraps at end of line
			if (lineEnd)
				hCount <= '0;
			else
				hCount <= hCount + 1'b1;
			// line count, steps once per line
			if (lineEnd)
			begin
				if (vCount == vLast)
					vCount <= '0;
				else
					vCount <= vCount + 1'b1;
			end
		end
	end

	// ===================================================================
	// stage 1 registers
	// ===================================================================

	// sync pulses are active low at the start of the line or frame
	always_ff @(posedge VGA_clk)
	begin
		if (reset)
		begin
			hSync <= 1'b1;
			vSync <= 1'b1;
			active <= 1'b0;
			frameStart <= 1'b0;
		end
		else
		begin
			hSync <= !(hCount < vgaPkg::coordT'(hSyncLen));
			vSync <= !(vCount < vgaPkg::coordT'(vSyncLen));
			active <= (hCount >= hStart) && (hCount < hEnd) &&
				(vCount >= vStart) && (vCount < vEnd);
			// one pulse per frame at counter origin
			frameStart <= (hCount == '0) && (vCount == '0);
		end
	end

	// coordinates relative to the visible origin
	// outside the window they wrap to large values
	always_ff @(posedge VGA_clk)
	begin
		xPos <= hCount - hStart;
		yPos <= vCount - vStart;
	end

	// counters never leave the line and the frame
	assert property (@(posedge VGA_clk) disable iff (reset)
		(hCount < hTotal) && (vCount < vTotal));

endmodule

// ==== vgaPkg.sv ====
// coordinate, colour and pixel class types with the default 1280x1024 timing constants
package vgaPkg;

	// ===================================================================
	// shared types
	// ===================================================================

	// pixel or counter coordinate
	// 11 bits covers the 1688 clocks of a full line
	typedef logic [10:0] coordT;

	// one colour channel
	typedef logic [7:0] colorT;

	// what a pixel shows, handed from the painter to the output stage
	typedef enum logic [1:0]
	{
		classBackground,
		classGrid,
		classItem
	} pixelClassT;

	// ===================================================================
	// default 1280x1024 at 60 Hz timing, in pixel clocks and lines
	// ===================================================================

	// horizontal
	localparam int defaultHTotal = 1688;
	localparam int defaultHVisible = 1280;
	localparam int defaultHSync = 112;
	localparam int defaultHBack = 248;

	// vertical
	localparam int defaultVTotal = 1066;
	localparam int defaultVVisible = 1024;
	localparam int defaultVSync = 3;
	localparam int defaultVBack = 38;

	// grid overlay
	// line spacing, same in both directions
	localparam int defaultGridPitch = 142;
	// line thickness
	localparam int defaultLineWidth = 10;

	// side of the item square
	localparam int defaultItemSize = 10;

endpackage
